// ==== rtl/legPipe_defs.svh ====
/* Sizes for the teaching pipeline. The instruction encoding assumes
   8 registers and a 16-bit word, so these values cannot change alone */
`ifndef LEG_PIPE_DEFS_SVH
`define LEG_PIPE_DEFS_SVH

// Data path, PC and instruction width
`define LEG_XLEN 16

// Architectural registers
`define LEG_NREGS 8

// Words of internal data memory
`define LEG_DMEM_DEPTH 16

`endif

// ==== rtl/legPipePkg.sv ====
/* Shared types for the five-stage pipeline
   Field widths follow the defines header */
`default_nettype none
`include "legPipe_defs.svh"

package legPipePkg;

  typedef logic [`LEG_XLEN-1:0] wordT;
  typedef logic [$clog2(`LEG_NREGS)-1:0] regT;

  // Three-bit opcode in the top of every instruction
  typedef enum logic [2:0] {
    opNop  = 3'd0,
    opAdd  = 3'd1,
    opSub  = 3'd2,
    opAddi = 3'd3,
    opLdr  = 3'd4,
    opStr  = 3'd5,
    opBeqz = 3'd6,
    opHalt = 3'd7
  } opT;

  // Register form
  typedef struct packed {
    opT         op;
    regT        rd, ra, rb;
    logic [3:0] unused;
  } rFormT;

  // Immediate form with a signed imm
  typedef struct packed {
    opT                op;
    regT               rd, ra;
    logic signed [6:0] imm;
  } iFormT;

  // One word seen through two views
  typedef union packed {
    rFormT rForm;
    iFormT iForm;
  } instrT;

  // Operand source picked in execute
  typedef enum logic [1:0] {
    fwdRf  = 2'b00,
    fwdWb  = 2'b01,
    fwdMem = 2'b10
  } fwdSelT;

  typedef struct packed {
    logic valid;
    opT   op;
    regT  rd, ra, rb;
    wordT a, b, imm, pc;
  } idExT;

  typedef struct packed {
    logic valid;
    opT   op;
    regT  rd;
    wordT result, storeData;
  } exMemT;

  typedef struct packed {
    logic valid;
    regT  rd;
    logic regWrite;
    wordT result;
  } memWbT;

  typedef struct packed {
    logic valid;
    regT  rd;
    wordT data;
  } wbT;

  typedef struct packed {
    regT  raE, rbE, rdE;
    logic loadE;
    regT  rdM;
    logic regWriteM;
    regT  rdW;
    logic regWriteW;
    regT  raD, rbD;
    logic useAD, useBD;
    logic branchTakenE;
    logic haltPending;
  } hazardInT;

  typedef struct packed {
    fwdSelT forwardA, forwardB;
    logic   stallF, stallD, flushD, flushE;
  } hazardCtlT;

endpackage

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
/* Pure combinational hazard control for the pipeline
   Assumes only loads need a stall and branches resolve in execute */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit
  import legPipePkg::*;
(
  input  hazardInT  hzIn,
  output hazardCtlT ctl
);

  logic ldrStall;
  logic useMatchA;
  logic useMatchB;

  // Newest producer wins, memory stage before writeback
  function automatic fwdSelT pickFwd(input regT src, input hazardInT h);
    if (h.regWriteM && (src == h.rdM))
      return fwdMem;
    else if (h.regWriteW && (src == h.rdW))
      return fwdWb;
    else
      return fwdRf;
  endfunction

  // Decode sources against the load in execute
  assign useMatchA = hzIn.useAD && (hzIn.raD == hzIn.rdE);
  assign useMatchB = hzIn.useBD && (hzIn.rbD == hzIn.rdE);

  // Load result is not ready until memory, so hold decode one cycle
  assign ldrStall = hzIn.loadE && (useMatchA || useMatchB);

  always_comb
  begin
    ctl.forwardA = pickFwd(hzIn.raE, hzIn);
    ctl.forwardB = pickFwd(hzIn.rbE, hzIn);

    // Load-use holds fetch and decode
    // Halt freezes fetch until reset, a taken branch still moves the PC
    ctl.stallF = ldrStall || (hzIn.haltPending && !hzIn.branchTakenE);
    ctl.stallD = ldrStall;

    // Taken branch kills the two younger instructions
    // After a halt nothing new enters decode
    ctl.flushD = hzIn.branchTakenE || hzIn.haltPending;

    // Bubble into execute on a load-use stall
    ctl.flushE = ldrStall || hzIn.branchTakenE;
  end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
/* Eight registers, two combinational reads, one write
   A read of the register written this cycle sees the new value */
`timescale 1ns/10ps
`default_nettype none
`include "legPipe_defs.svh"

module regFile
  import legPipePkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  regT   raA, raB,
  output wordT  rdA, rdB,
  input  memWbT wb
);

  wordT regs [`LEG_NREGS];
  logic wrEn;

  assign wrEn = wb.valid && wb.regWrite;

  // All registers clear on reset
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `LEG_NREGS; i++)
        regs[i] <= '0;
    end
    else if (wrEn)
      regs[wb.rd] <= wb.result;
  end

  // Write-through covers writeback to decode
  assign rdA = (wrEn && (wb.rd == raA)) ? wb.result : regs[raA];
  assign rdB = (wrEn && (wb.rd == raB)) ? wb.result : regs[raB];

endmodule

`default_nettype wire

// ==== rtl/execStage.sv ====
/* Execute stage, combinational, zero latency
   BEQZ tests operand A, target is pc plus one plus imm */
`timescale 1ns/10ps
`default_nettype none

module execStage
  import legPipePkg::*;
(
  input  idExT   ex,
  input  fwdSelT forwardA, forwardB,
  input  wordT   memResult, wbResult,
  output exMemT  exOut,
  output logic   branchTaken,
  output wordT   branchTarget
);

  wordT opA;
  wordT opB;

  // Operand mux shared by both sources
  function automatic wordT pickOperand(input fwdSelT sel, input wordT rfVal,
                                       input wordT memVal, input wordT wbVal);
    case (sel)
      fwdMem:  return memVal;
      fwdWb:   return wbVal;
      default: return rfVal;
    endcase
  endfunction

  assign opA = pickOperand(forwardA, ex.a, memResult, wbResult);
  assign opB = pickOperand(forwardB, ex.b, memResult, wbResult);

  always_comb
  begin
    exOut.valid = ex.valid;
    exOut.op    = ex.op;
    exOut.rd    = ex.rd;
    // Store data rides in operand B
    exOut.storeData = opB;

    case (ex.op)
      opAdd:
        exOut.result = opA + opB;
      opSub:
        exOut.result = opA - opB;
      // Same adder for add-immediate and load/store address
      opAddi, opLdr, opStr:
        exOut.result = opA + ex.imm;
      default:
        exOut.result = '0;
    endcase
  end

  // Branch on zero, resolved here
  assign branchTaken  = ex.valid && (ex.op == opBeqz) && (opA == '0);
  assign branchTarget = ex.pc + wordT'(1) + ex.imm;

endmodule

`default_nettype wire

// ==== rtl/dataMem.sv ====
/* 16-word data memory, written on the clock and read combinationally
   Only the low address bits are used, so addresses wrap */
`timescale 1ns/10ps
`default_nettype none
`include "legPipe_defs.svh"

module dataMem
  import legPipePkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  exMemT mem,
  output wordT  loadData
);

  localparam int AddrW = $clog2(`LEG_DMEM_DEPTH);

  wordT             words [`LEG_DMEM_DEPTH];
  logic [AddrW-1:0] addr;

  // Address comes from the execute adder
  assign addr = mem.result[AddrW-1:0];

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `LEG_DMEM_DEPTH; i++)
        words[i] <= '0;
    end
    else if (mem.valid && (mem.op == opStr))
      words[addr] <= mem.storeData;
  end

  // Top picks this up only for LDR
  assign loadData = words[addr];

endmodule

`default_nettype wire

// ==== rtl/legPipe.sv ====
/* Five-stage in-order pipeline, instruction memory served outside
   instr must return combinationally for the pc of the same cycle */
`timescale 1ns/10ps
`default_nettype none
`include "legPipe_defs.svh"

module legPipe
  import legPipePkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  output wordT  pc,
  input  instrT instr,
  output wbT    retire,
  output logic  halted
);

  // Decode stage state
  instrT instrD;
  wordT  pcD;
  logic  validD;
  logic  haltPending;

  // Decode fields
  opT   opD;
  regT  raD, rbD;
  logic useAD, useBD;
  wordT rfA, rfB;

  // Pipeline registers
  idExT  idEx, idExNext;
  exMemT exMem, exOut;
  memWbT memWb;

  hazardInT  hzIn;
  hazardCtlT ctl;
  logic      branchTaken;
  wordT      branchTarget;
  wordT      loadData;
  wordT      memResult;

  function automatic logic writesReg(input opT op);
    return op inside {opAdd, opSub, opAddi, opLdr};
  endfunction

  // Fetch, a taken branch overrides any stall
  always_ff @(posedge clk)
  begin
    if (!rstN)
      pc <= '0;
    else if (branchTaken)
      pc <= branchTarget;
    else if (!ctl.stallF)
      pc <= pc + wordT'(1);
  end

  // Fetch to decode, flush beats stall
  always_ff @(posedge clk)
  begin
    if (!rstN)
      validD <= 1'b0;
    else if (ctl.flushD)
      validD <= 1'b0;
    else if (!ctl.stallD)
      validD <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!ctl.stallD)
    begin
      instrD <= instr;
      pcD    <= pc;
    end
  end

  // Decode through both views of the word
  assign opD = instrD.rForm.op;
  assign raD = instrD.rForm.ra;
  // STR reads its data register from the rd field
  assign rbD = (opD == opStr) ? instrD.iForm.rd : instrD.rForm.rb;
  assign useAD = validD && (opD inside {opAdd, opSub, opAddi, opLdr, opStr, opBeqz});
  assign useBD = validD && (opD inside {opAdd, opSub, opStr});

  regFile uRegFile (
    .clk  (clk),
    .rstN (rstN),
    .raA  (raD),
    .raB  (rbD),
    .rdA  (rfA),
    .rdB  (rfB),
    .wb   (memWb)
  );

  always_comb
  begin
    idExNext.valid = validD;
    idExNext.op    = opD;
    idExNext.rd    = instrD.rForm.rd;
    idExNext.ra    = raD;
    idExNext.rb    = rbD;
    idExNext.a     = rfA;
    idExNext.b     = rfB;
    // Sign-extend the 7-bit immediate
    idExNext.imm   = {{(`LEG_XLEN-7){instrD.iForm.imm[6]}}, instrD.iForm.imm};
    idExNext.pc    = pcD;
  end

  // HALT sticks once it leaves decode unflushed
  always_ff @(posedge clk)
  begin
    if (!rstN)
      haltPending <= 1'b0;
    else if (validD && (opD == opHalt) && !ctl.flushD)
      haltPending <= 1'b1;
  end

  // Decode to execute, flush leaves a bubble
  always_ff @(posedge clk)
  begin
    if (!rstN)
      idEx.valid <= 1'b0;
    else if (ctl.flushE)
      idEx.valid <= 1'b0;
    else
      idEx <= idExNext;
  end

  execStage uExec (
    .ex           (idEx),
    .forwardA     (ctl.forwardA),
    .forwardB     (ctl.forwardB),
    .memResult    (memResult),
    .wbResult     (memWb.result),
    .exOut        (exOut),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

  // Execute to memory
  always_ff @(posedge clk)
  begin
    if (!rstN)
      exMem.valid <= 1'b0;
    else
      exMem <= exOut;
  end

  dataMem uDataMem (
    .clk      (clk),
    .rstN     (rstN),
    .mem      (exMem),
    .loadData (loadData)
  );

  // Load data is ready here, so it forwards from memory too
  assign memResult = (exMem.op == opLdr) ? loadData : exMem.result;

  // Memory to writeback
  always_ff @(posedge clk)
  begin
    if (!rstN)
      memWb.valid <= 1'b0;
    else
    begin
      memWb.valid    <= exMem.valid;
      memWb.rd       <= exMem.rd;
      memWb.regWrite <= exMem.valid && writesReg(exMem.op);
      memWb.result   <= memResult;
    end
  end

  // Rises as HALT enters writeback
  always_ff @(posedge clk)
  begin
    if (!rstN)
      halted <= 1'b0;
    else if (exMem.valid && (exMem.op == opHalt))
      halted <= 1'b1;
  end

  always_comb
  begin
    hzIn.raE          = idEx.ra;
    hzIn.rbE          = idEx.rb;
    hzIn.rdE          = idEx.rd;
    hzIn.loadE        = idEx.valid && (idEx.op == opLdr);
    hzIn.rdM          = exMem.rd;
    hzIn.regWriteM    = exMem.valid && writesReg(exMem.op);
    hzIn.rdW          = memWb.rd;
    hzIn.regWriteW    = memWb.valid && memWb.regWrite;
    hzIn.raD          = raD;
    hzIn.rbD          = rbD;
    hzIn.useAD        = useAD;
    hzIn.useBD        = useBD;
    hzIn.branchTakenE = branchTaken;
    hzIn.haltPending  = haltPending;
  end

  hazardUnit uHazard (
    .hzIn (hzIn),
    .ctl  (ctl)
  );

  // Retire in the cycle of the register write
  assign retire = '{valid: memWb.valid && memWb.regWrite, rd: memWb.rd, data: memWb.result};

endmodule

`default_nettype wire

// ==== verif/legPipeTb.sv ====
/* Random-program testbench for the pipeline, checked against an ISA model
   Branches are forward only and HALT ends every program, so each run terminates */
`timescale 1ns/10ps
`default_nettype none
`include "legPipe_defs.svh"

module legPipeTb
  import legPipePkg::*;
();

  localparam int ProgLen     = 48;
  localparam int NumProgs    = 5;
  localparam int RunTimeout  = 1000;
  localparam int DrainCycles = 8;

  logic  clk;
  logic  rstN;
  wordT  pc;
  instrT instr;
  wbT    retire;
  logic  halted;

  logic [15:0] prog [ProgLen];
  logic [15:0] lfsr;

  // Expected register writes in retire order
  int expRd[$];
  int expData[$];

  legPipe UUT (
    .clk    (clk),
    .rstN   (rstN),
    .pc     (pc),
    .instr  (instr),
    .retire (retire),
    .halted (halted)
  );

  // Past the program end the fetch sees NOP
  function automatic logic [15:0] fetchWord(input logic [15:0] addr);
    if (addr < 16'(ProgLen))
      return prog[addr[5:0]];
    return 16'h0000;
  endfunction

  // Instruction memory answers in the same cycle
  always_comb
    instr = fetchWord(pc);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
  function automatic logic stepBit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic int randBits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
      v = (v << 1) | int'(stepBit());
    return v;
  endfunction

  task automatic checkEq(input logic [31:0] expected, input logic [31:0] actual,
                         input string what);
    if (expected !== actual)
    begin
      $display("[FAIL] %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abortRun(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  // All fields random and the opcode picks which of them matter
  task automatic buildProgram();
    int opSel;
    int imm;
    for (int i = 0; i < ProgLen - 1; i++)
    begin
      opSel = randBits(3);
      // HALT code folds onto LDR, so loads show up twice as often
      if (opSel == 7)
        opSel = 4;
      prog[i] = {3'(opSel), 13'(randBits(13))};
      if (opSel == int'(opBeqz))
      begin
        // Short forward hop that never passes the final HALT
        imm = randBits(2);
        if (i + 1 + imm > ProgLen - 1)
          imm = ProgLen - 2 - i;
        prog[i][6:0] = 7'(imm);
      end
    end
    prog[ProgLen - 1] = {3'(opHalt), 13'd0};
  endtask

  // Architectural interpreter stepping one instruction at a time
  task automatic runModel();
    logic [15:0] regs [`LEG_NREGS];
    logic [15:0] mem [`LEG_DMEM_DEPTH];
    logic [15:0] w;
    logic [15:0] imm;
    logic [15:0] res;
    logic [15:0] addr;
    logic [15:0] pcM;
    logic        wr;
    logic        done;
    expRd.delete();
    expData.delete();
    for (int r = 0; r < `LEG_NREGS; r++)
      regs[r] = 16'h0;
    for (int m = 0; m < `LEG_DMEM_DEPTH; m++)
      mem[m] = 16'h0;
    pcM  = 16'h0;
    done = 1'b0;
    while (!done && (pcM < 16'(ProgLen)))
    begin
      w    = fetchWord(pcM);
      imm  = {{9{w[6]}}, w[6:0]};
      addr = regs[w[9:7]] + imm;
      pcM  = pcM + 16'd1;
      wr   = 1'b0;
      res  = 16'h0;
      case (opT'(w[15:13]))
        opAdd:
        begin
          res = regs[w[9:7]] + regs[w[6:4]];
          wr  = 1'b1;
        end
        opSub:
        begin
          res = regs[w[9:7]] - regs[w[6:4]];
          wr  = 1'b1;
        end
        opAddi:
        begin
          res = addr;
          wr  = 1'b1;
        end
        opLdr:
        begin
          res = mem[addr[3:0]];
          wr  = 1'b1;
        end
        // Store data comes from the rd field
        opStr:
          mem[addr[3:0]] = regs[w[12:10]];
        opBeqz:
          if (regs[w[9:7]] == 16'h0)
            pcM = pcM + imm;
        opHalt:
          done = 1'b1;
        default:
          wr = 1'b0;
      endcase
      if (wr)
      begin
        regs[w[12:10]] = res;
        expRd.push_back(int'(w[12:10]));
        expData.push_back(int'(res));
      end
    end
  endtask

  task automatic runProgram(input int progIdx);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    // Retire is settled at the falling edge
    while (!halted)
    begin
      @(negedge clk);
      if (retire.valid)
      begin
        if (seen >= expRd.size())
          abortRun($sformatf("program %0d retired more writes than the model", progIdx));
        checkEq(expRd[seen], retire.rd,
                $sformatf("program %0d write %0d rd", progIdx, seen));
        checkEq(expData[seen], retire.data,
                $sformatf("program %0d write %0d data", progIdx, seen));
        seen++;
      end
      cycles++;
      if (cycles > RunTimeout)
        abortRun($sformatf("program %0d did not halt within %0d cycles", progIdx, RunTimeout));
    end
    checkEq(expRd.size(), seen, $sformatf("program %0d writes before halt", progIdx));
    // Nothing may retire once halted
    repeat (DrainCycles)
    begin
      @(negedge clk);
      checkEq(0, retire.valid, $sformatf("program %0d write after halt", progIdx));
      checkEq(1, halted, $sformatf("program %0d halted dropped", progIdx));
    end
  endtask

  initial
  begin
    rstN = 1'b0;
    lfsr = 16'd25070;
    for (int p = 0; p < NumProgs; p++)
    begin
      @(posedge clk);
      #0.5;
      rstN = 1'b0;
      buildProgram();
      runModel();
      repeat (2) @(posedge clk);
      #0.5;
      // Reset state before release
      checkEq(0, pc, "pc after reset");
      checkEq(0, retire.valid, "retire valid after reset");
      checkEq(0, halted, "halted after reset");
      rstN = 1'b1;
      runProgram(p);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== legPipe.f ====
+incdir+rtl
rtl/legPipePkg.sv
rtl/hazardUnit.sv
rtl/regFile.sv
rtl/execStage.sv
rtl/dataMem.sv
rtl/legPipe.sv
verif/legPipeTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f legPipe.f --top-module legPipeTb -o legPipeSim

# The simulator exits nonzero on a failed check, the log decides
./obj_dir/legPipeSim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  exit 1
fi
exit 0
